// ==== source/sd_pkg.sv ====
package sd_pkg;

  typedef logic [5:0]  cmd_index_t;
  typedef logic [31:0] cmd_arg_t;
  typedef logic [7:0]  r1_t;
  // card clock half-period in system clock cycles
  typedef logic [15:0] clk_div_t;

  typedef struct packed {
    cmd_index_t index;
    cmd_arg_t   arg;
  } sd_cmd_t;

  // payload holds the trailing four bytes of R7/R3
  typedef struct packed {
    r1_t         r1;
    logic [31:0] payload;
    logic        timed_out;
  } sd_resp_t;

  typedef enum logic [2:0] {
    st_power_wait,
    st_issue,
    st_cmd_wait,
    st_resp_wait,
    st_done,
    st_error
  } init_state_e;

  localparam int cmd_frame_bits     = 48;
  localparam int resp_short_bits    = 8;
  localparam int resp_long_bits     = 40;
  localparam int resp_timeout_ticks = 100;
  localparam int max_retries        = 10;

  localparam r1_t r1_idle         = 8'h01;
  localparam r1_t r1_ready        = 8'h00;
  localparam r1_t r1_illegal_idle = 8'h05;

  // 2.7-3.6 V plus check pattern
  localparam cmd_arg_t cmd8_arg   = 32'h0000_01AA;
  // HCS set
  localparam cmd_arg_t acmd41_arg = 32'h4000_0000;
  localparam logic [7:0] check_pattern = 8'hAA;
  localparam logic [3:0] voltage_ok    = 4'h1;

  localparam cmd_index_t cmd0_idx   = 6'd0;
  localparam cmd_index_t cmd8_idx   = 6'd8;
  localparam cmd_index_t cmd55_idx  = 6'd55;
  localparam cmd_index_t acmd41_idx = 6'd41;
  localparam cmd_index_t cmd58_idx  = 6'd58;

  localparam clk_div_t default_slow_div = 16'd125;
  localparam clk_div_t default_fast_div = 16'd2;
  localparam int unsigned default_init_wait = 1_000_000;

endpackage

// ==== source/sd_clk_gen.sv ====
`timescale 1ns/1ps

module sd_clk_gen import sd_pkg::*; #(
  parameter clk_div_t slow_div = default_slow_div,
  parameter clk_div_t fast_div = default_fast_div
) (
  input  logic clk,
  input  logic rst_n,
  input  logic fast_clk,
  output logic sd_cclk,
  output logic fall_tick,
  output logic rise_tick
);

  clk_div_t div;
  clk_div_t cnt_q;

  assign div = fast_clk ? fast_div : slow_div;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q     <= slow_div - 16'd1;
      sd_cclk   <= 1'b0;
      fall_tick <= 1'b0;
      rise_tick <= 1'b0;
    end else if (cnt_q == '0) begin
      // toggle and flag which edge was made
      cnt_q     <= div - 16'd1;
      sd_cclk   <= ~sd_cclk;
      fall_tick <= sd_cclk;
      rise_tick <= ~sd_cclk;
    end else begin
      cnt_q     <= cnt_q - 16'd1;
      fall_tick <= 1'b0;
      rise_tick <= 1'b0;
    end
  end

endmodule

// ==== source/sd_cmd_tx.sv ====
`timescale 1ns/1ps

module sd_cmd_tx import sd_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    cmd_start,
  input  sd_cmd_t cmd,
  input  logic    fall_tick,
  output logic    sd_cmd,
  output logic    cmd_done
);

  // start, transmission, index and argument
  logic [39:0] head_q;
  logic [6:0]  crc_q;
  logic [5:0]  bit_cnt_q;
  logic        busy_q;
  logic        crc_fb;

  // CRC7 feedback, generator x^7 + x^3 + 1
  assign crc_fb = head_q[39] ^ crc_q[6];

  always_ff @(posedge clk) begin
    if (cmd_start) begin
      head_q <= {2'b01, cmd.index, cmd.arg};
      crc_q  <= '0;
    end else if (busy_q && fall_tick) begin
      if (bit_cnt_q < 6'(cmd_frame_bits - 8)) begin
        head_q <= {head_q[38:0], 1'b0};
        crc_q  <= {crc_q[5:0], 1'b0} ^ (crc_fb ? 7'h09 : 7'h00);
      end else begin
        crc_q <= {crc_q[5:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sd_cmd    <= 1'b1;
      cmd_done  <= 1'b0;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      if (cmd_start) begin
        busy_q    <= 1'b1;
        bit_cnt_q <= '0;
      end else if (busy_q && fall_tick) begin
        bit_cnt_q <= bit_cnt_q + 6'd1;
        if (bit_cnt_q < 6'(cmd_frame_bits - 8)) begin
          sd_cmd <= head_q[39];
        end else if (bit_cnt_q < 6'(cmd_frame_bits - 1)) begin
          sd_cmd <= crc_q[6];
        end else begin
          // stop bit, then one more period before done
          sd_cmd <= 1'b1;
          if (bit_cnt_q == 6'(cmd_frame_bits)) begin
            busy_q   <= 1'b0;
            cmd_done <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== source/sd_resp_rx.sv ====
`timescale 1ns/1ps

module sd_resp_rx import sd_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     resp_start,
  input  logic     resp_long,
  input  logic     rise_tick,
  input  logic     sd_data0,
  output logic     resp_done,
  output sd_resp_t resp
);

  logic                      busy_q;
  logic                      hunt_q;
  logic                      long_q;
  logic [5:0]                bit_cnt_q;
  logic [7:0]                tick_cnt_q;
  logic [resp_long_bits-1:0] shift_q;
  logic [resp_long_bits-1:0] shift_next;
  logic [5:0]                last_bit;
  logic                      capture;
  logic                      timeout_hit;
  logic                      last_hit;

  assign shift_next  = {shift_q[resp_long_bits-2:0], sd_data0};
  assign last_bit    = long_q ? 6'(resp_long_bits - 1) : 6'(resp_short_bits - 1);
  // still hunting while the line stays high
  assign capture     = busy_q && rise_tick && !(hunt_q && sd_data0);
  assign timeout_hit = busy_q && rise_tick && hunt_q && sd_data0 &&
                       (tick_cnt_q == 8'(resp_timeout_ticks - 1));
  assign last_hit    = capture && (bit_cnt_q == last_bit);

  always_ff @(posedge clk) begin
    if (capture) begin
      shift_q <= shift_next;
    end
    if (timeout_hit) begin
      resp <= '{r1: '1, payload: '0, timed_out: 1'b1};
    end else if (last_hit) begin
      resp.r1        <= long_q ? shift_next[39:32] : shift_next[7:0];
      resp.payload   <= long_q ? shift_next[31:0] : '0;
      resp.timed_out <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      hunt_q     <= 1'b0;
      long_q     <= 1'b0;
      bit_cnt_q  <= '0;
      tick_cnt_q <= '0;
      resp_done  <= 1'b0;
    end else begin
      resp_done <= timeout_hit || last_hit;
      if (resp_start) begin
        busy_q     <= 1'b1;
        hunt_q     <= 1'b1;
        long_q     <= resp_long;
        bit_cnt_q  <= '0;
        tick_cnt_q <= '0;
      end else if (timeout_hit || last_hit) begin
        busy_q <= 1'b0;
      end else if (capture) begin
        hunt_q    <= 1'b0;
        bit_cnt_q <= bit_cnt_q + 6'd1;
      end else if (busy_q && rise_tick) begin
        tick_cnt_q <= tick_cnt_q + 8'd1;
      end
    end
  end

endmodule

// ==== source/sd_init_fsm.sv ====
`timescale 1ns/1ps

module sd_init_fsm import sd_pkg::*; #(
  parameter int unsigned init_wait = default_init_wait
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_done,
  input  logic     resp_done,
  input  sd_resp_t resp,
  output logic     cmd_start,
  output sd_cmd_t  cmd,
  output logic     resp_start,
  output logic     resp_long,
  output logic     fast_clk,
  output logic     sd_cs,
  output logic     init_done,
  output logic     init_error,
  output logic     high_capacity
);

  init_state_e state_q;
  logic [31:0] wait_cnt_q;
  logic [3:0]  cmd0_tries_q;
  logic [3:0]  acmd41_tries_q;
  // set once ACMD41 reports ready, marks the second CMD58
  logic        card_ready_q;
  logic        cmd8_ok;

  // only CMD8 (R7) and CMD58 (R3) carry the four trailing bytes
  assign resp_long = (cmd.index == cmd8_idx) || (cmd.index == cmd58_idx);

  // v1 card rejects CMD8, v2 card must echo voltage and pattern
  assign cmd8_ok = (resp.r1 == r1_illegal_idle) ||
                   ((resp.r1 == r1_idle) && (resp.payload[11:8] == voltage_ok) &&
                    (resp.payload[7:0] == check_pattern));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= st_power_wait;
      wait_cnt_q     <= '0;
      cmd0_tries_q   <= '0;
      acmd41_tries_q <= '0;
      card_ready_q   <= 1'b0;
      cmd_start      <= 1'b0;
      cmd            <= '0;
      resp_start     <= 1'b0;
      fast_clk       <= 1'b0;
      sd_cs          <= 1'b1;
      init_done      <= 1'b0;
      init_error     <= 1'b0;
      high_capacity  <= 1'b0;
    end else begin
      cmd_start  <= 1'b0;
      resp_start <= 1'b0;
      case (state_q)
        st_power_wait: begin
          wait_cnt_q <= wait_cnt_q + 32'd1;
          if (wait_cnt_q == 32'(init_wait - 1)) begin
            sd_cs   <= 1'b0;
            cmd     <= '{index: cmd0_idx, arg: '0};
            state_q <= st_issue;
          end
        end
        st_issue: begin
          cmd_start <= 1'b1;
          state_q   <= st_cmd_wait;
        end
        st_cmd_wait: begin
          if (cmd_done) begin
            resp_start <= 1'b1;
            state_q    <= st_resp_wait;
          end
        end
        st_resp_wait: begin
          if (resp_done) begin
            state_q <= st_issue;
            case (cmd.index)
              cmd0_idx: begin
                if (resp.timed_out || resp.r1 != r1_idle) begin
                  // resend CMD0 unless out of tries
                  if (cmd0_tries_q == 4'(max_retries - 1)) begin
                    state_q <= st_error;
                  end
                  cmd0_tries_q <= cmd0_tries_q + 4'd1;
                end else begin
                  cmd <= '{index: cmd8_idx, arg: cmd8_arg};
                end
              end
              cmd8_idx: begin
                if (cmd8_ok) begin
                  cmd <= '{index: cmd58_idx, arg: '0};
                end else begin
                  state_q <= st_error;
                end
              end
              cmd58_idx: begin
                if (card_ready_q) begin
                  if (resp.timed_out) begin
                    state_q <= st_error;
                  end else begin
                    // OCR bit 30 is CCS
                    high_capacity <= resp.payload[30];
                    fast_clk      <= 1'b1;
                    state_q       <= st_done;
                  end
                end else if (resp.r1 == r1_idle) begin
                  cmd <= '{index: cmd55_idx, arg: '0};
                end else begin
                  state_q <= st_error;
                end
              end
              cmd55_idx: begin
                if (resp.r1 == r1_idle || resp.r1 == r1_ready) begin
                  cmd <= '{index: acmd41_idx, arg: acmd41_arg};
                end else begin
                  state_q <= st_error;
                end
              end
              acmd41_idx: begin
                if (resp.r1 == r1_ready) begin
                  card_ready_q <= 1'b1;
                  cmd          <= '{index: cmd58_idx, arg: '0};
                end else if (resp.r1 == r1_idle) begin
                  // still initializing, go round the pair again
                  if (acmd41_tries_q == 4'(max_retries - 1)) begin
                    state_q <= st_error;
                  end
                  acmd41_tries_q <= acmd41_tries_q + 4'd1;
                  cmd            <= '{index: cmd55_idx, arg: '0};
                end else begin
                  state_q <= st_error;
                end
              end
              default: state_q <= st_error;
            endcase
          end
        end
        st_done:  init_done  <= 1'b1;
        st_error: init_error <= 1'b1;
        default:  state_q    <= st_error;
      endcase
    end
  end

endmodule

// ==== source/sd_spi_init.sv ====
`timescale 1ns/1ps

module sd_spi_init import sd_pkg::*; #(
  parameter clk_div_t    slow_div  = default_slow_div,
  parameter clk_div_t    fast_div  = default_fast_div,
  parameter int unsigned init_wait = default_init_wait
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sd_data0,
  output logic sd_cclk,
  output logic sd_cmd,
  output logic sd_cs,
  output logic init_done,
  output logic init_error,
  output logic high_capacity
);

  logic     fast_clk;
  logic     fall_tick;
  logic     rise_tick;
  logic     cmd_start;
  logic     cmd_done;
  sd_cmd_t  cmd;
  logic     resp_start;
  logic     resp_long;
  logic     resp_done;
  sd_resp_t resp;

  sd_init_fsm #(
    .init_wait(init_wait)
  ) i_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_done     (cmd_done),
    .resp_done    (resp_done),
    .resp         (resp),
    .cmd_start    (cmd_start),
    .cmd          (cmd),
    .resp_start   (resp_start),
    .resp_long    (resp_long),
    .fast_clk     (fast_clk),
    .sd_cs        (sd_cs),
    .init_done    (init_done),
    .init_error   (init_error),
    .high_capacity(high_capacity)
  );

  sd_clk_gen #(
    .slow_div(slow_div),
    .fast_div(fast_div)
  ) i_clk_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .fast_clk (fast_clk),
    .sd_cclk  (sd_cclk),
    .fall_tick(fall_tick),
    .rise_tick(rise_tick)
  );

  sd_cmd_tx i_cmd_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_start(cmd_start),
    .cmd      (cmd),
    .fall_tick(fall_tick),
    .sd_cmd   (sd_cmd),
    .cmd_done (cmd_done)
  );

  sd_resp_rx i_resp_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .resp_start(resp_start),
    .resp_long (resp_long),
    .rise_tick (rise_tick),
    .sd_data0  (sd_data0),
    .resp_done (resp_done),
    .resp      (resp)
  );

endmodule

// ==== verif/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model import sd_pkg::*; (
  input  logic rst_n,
  input  logic sd_cclk,
  input  logic sd_cs,
  input  logic sd_cmd,
  input  int   cmd0_fails,
  input  logic v1_card,
  input  logic bad_pattern,
  input  int   idle_count,
  input  logic ccs,
  input  logic silent,
  output logic sd_data0
);

  bit [47:0]  frame;
  int         frame_bits;
  int         cmd0_seen;
  int         acmd41_seen;
  bit         powered_up;
  int         crc_errors;
  int         log_cnt;
  cmd_index_t log_idx [64];
  bit         reply_q [$];
  bit         data_q = 1'b1;

  assign sd_data0 = data_q;

  // remainder of head * x^7 divided by x^7 + x^3 + 1
  function automatic logic [6:0] frame_crc7(input logic [39:0] head);
    logic [46:0] rem;
    rem = {head, 7'b0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) begin
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
    end
    return rem[6:0];
  endfunction

  task automatic queue_reply(input r1_t r1, input logic [31:0] payload, input bit long_resp);
    // one byte of idle line before the response
    for (int i = 0; i < 8; i++) begin
      reply_q.push_back(1'b1);
    end
    for (int i = 7; i >= 0; i--) begin
      reply_q.push_back(r1[i]);
    end
    if (long_resp) begin
      for (int i = 31; i >= 0; i--) begin
        reply_q.push_back(payload[i]);
      end
    end
  endtask

  task automatic answer(input cmd_index_t index, input cmd_arg_t arg);
    r1_t        state_r1;
    logic [7:0] echo;
    state_r1 = powered_up ? r1_ready : r1_idle;
    echo     = bad_pattern ? ~arg[7:0] : arg[7:0];
    case (index)
      cmd0_idx: begin
        // the first cmd0_fails resets go unanswered
        if (cmd0_seen >= cmd0_fails) begin
          queue_reply(r1_idle, '0, 1'b0);
        end
        cmd0_seen++;
      end
      cmd8_idx: begin
        if (v1_card) begin
          queue_reply(r1_illegal_idle, '0, 1'b0);
        end else begin
          queue_reply(r1_idle, {20'h0, arg[11:8], echo}, 1'b1);
        end
      end
      cmd55_idx: queue_reply(state_r1, '0, 1'b0);
      acmd41_idx: begin
        if (acmd41_seen >= idle_count) begin
          powered_up = 1'b1;
        end
        acmd41_seen++;
        queue_reply(powered_up ? r1_ready : r1_idle, '0, 1'b0);
      end
      // OCR: power-up status, CCS, 2.7-3.6 V window
      cmd58_idx: queue_reply(state_r1, {powered_up, powered_up & ccs, 6'h0, 24'hFF_8000}, 1'b1);
      default:   queue_reply(8'h04, '0, 1'b0);
    endcase
  endtask

  always @(posedge sd_cclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_bits  = 0;
      cmd0_seen   = 0;
      acmd41_seen = 0;
      powered_up  = 1'b0;
      crc_errors  = 0;
      log_cnt     = 0;
      reply_q.delete();
    end else if (!sd_cs) begin
      // a frame opens with its start bit at 0
      if (frame_bits > 0 || !sd_cmd) begin
        frame = {frame[46:0], sd_cmd};
        frame_bits++;
      end
      if (frame_bits == cmd_frame_bits) begin
        frame_bits = 0;
        if (frame_crc7(frame[47:8]) != frame[7:1]) begin
          crc_errors++;
        end
        if (log_cnt < 64) begin
          log_idx[log_cnt] = frame[45:40];
          log_cnt++;
        end
        if (!silent) begin
          answer(frame[45:40], frame[39:8]);
        end
      end
    end
  end

  always @(negedge sd_cclk or negedge rst_n) begin
    if (!rst_n) begin
      data_q <= 1'b1;
    end else if (reply_q.size() != 0) begin
      data_q <= reply_q.pop_front();
    end else begin
      data_q <= 1'b1;
    end
  end

endmodule

// ==== verif/tb_sd_spi_init.sv ====
`timescale 1ns/1ps

module tb_sd_spi_init import sd_pkg::*;;

  localparam int       clk_period = 40;
  localparam clk_div_t slow_div   = 16'd4;
  localparam clk_div_t fast_div   = 16'd2;
  localparam int       init_wait  = 200;
  // frame, response timeout and slack, in card clock periods
  localparam int cmd_periods = cmd_frame_bits + resp_timeout_ticks + 16;
  // worst-case command counts of the six tests
  localparam int total_cmds = 6 + 12 + 8 + 10 + 2 + 23;
  localparam int watchdog_cycles = total_cmds * cmd_periods * 2 * int'(slow_div) +
                                   6 * (init_wait + 16 + 200);

  logic clk;
  logic rst_n;
  logic sd_data0;
  logic sd_cclk;
  logic sd_cmd;
  logic sd_cs;
  logic init_done;
  logic init_error;
  logic high_capacity;
  int   cmd0_fails;
  logic v1_card;
  logic bad_pattern;
  int   idle_count;
  logic ccs;
  logic silent;
  int   errors = 0;

  sd_spi_init #(
    .slow_div (slow_div),
    .fast_div (fast_div),
    .init_wait(init_wait)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sd_data0     (sd_data0),
    .sd_cclk      (sd_cclk),
    .sd_cmd       (sd_cmd),
    .sd_cs        (sd_cs),
    .init_done    (init_done),
    .init_error   (init_error),
    .high_capacity(high_capacity)
  );

  sd_card_model card (
    .rst_n      (rst_n),
    .sd_cclk    (sd_cclk),
    .sd_cs      (sd_cs),
    .sd_cmd     (sd_cmd),
    .cmd0_fails (cmd0_fails),
    .v1_card    (v1_card),
    .bad_pattern(bad_pattern),
    .idle_count (idle_count),
    .ccs        (ccs),
    .silent     (silent),
    .sd_data0   (sd_data0)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired, no result after %0d clock cycles", watchdog_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
    errors++;
  endtask

  function automatic int count_index(input cmd_index_t idx);
    int n;
    n = 0;
    for (int i = 0; i < card.log_cnt; i++) begin
      if (card.log_idx[i] == idx) begin
        n++;
      end
    end
    return n;
  endfunction

  // card behavior, then reset and a look at the idle outputs
  task automatic start_test(input int c0_fails, input bit v1, input bit bad,
                            input int idles, input bit cap, input bit quiet);
    @(posedge clk);
    cmd0_fails  <= c0_fails;
    v1_card     <= v1;
    bad_pattern <= bad;
    idle_count  <= idles;
    ccs         <= cap;
    silent      <= quiet;
    rst_n       <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (sd_cs !== 1'b1) report_mismatch("sd_cs", int'(sd_cs), 1);
    if (sd_cmd !== 1'b1) report_mismatch("sd_cmd", int'(sd_cmd), 1);
    if (init_done !== 1'b0) report_mismatch("init_done", int'(init_done), 0);
  endtask

  task automatic wait_outcome(input bit done_exp);
    while (!init_done && !init_error) @(negedge clk);
    repeat (4) @(negedge clk);
    if (init_done !== done_exp) report_mismatch("init_done", int'(init_done), int'(done_exp));
    if (init_error !== !done_exp) report_mismatch("init_error", int'(init_error), int'(!done_exp));
    if (card.crc_errors != 0) begin
      $display("[FAIL] %0t card saw %0d frames with a bad CRC7", $time, card.crc_errors);
      errors++;
    end
  endtask

  task automatic standard_hc_card();
    cmd_index_t std_seq [6] = '{cmd0_idx, cmd8_idx, cmd58_idx, cmd55_idx, acmd41_idx, cmd58_idx};
    time        t_rise;
    start_test(0, 1'b0, 1'b0, 0, 1'b1, 1'b0);
    wait_outcome(1'b1);
    if (high_capacity !== 1'b1) report_mismatch("high_capacity", int'(high_capacity), 1);
    if (card.log_cnt != 6) begin
      report_mismatch("command count", card.log_cnt, 6);
    end else begin
      for (int i = 0; i < 6; i++) begin
        if (card.log_idx[i] != std_seq[i]) begin
          report_mismatch("command index", int'(card.log_idx[i]), int'(std_seq[i]));
        end
      end
    end
    // card clock now at the fast rate
    repeat (2) @(posedge sd_cclk);
    t_rise = $time;
    @(negedge sd_cclk);
    if (($time - t_rise) != time'(fast_div) * clk_period) begin
      report_mismatch("sd_cclk high cycles", int'(($time - t_rise) / clk_period), int'(fast_div));
    end
  endtask

  task automatic idle_then_ready();
    start_test(0, 1'b0, 1'b0, 3, 1'b0, 1'b0);
    wait_outcome(1'b1);
    if (count_index(cmd55_idx) != 4) report_mismatch("CMD55 count", count_index(cmd55_idx), 4);
    if (count_index(acmd41_idx) != 4) begin
      report_mismatch("ACMD41 count", count_index(acmd41_idx), 4);
    end
    if (high_capacity !== 1'b0) report_mismatch("high_capacity", int'(high_capacity), 0);
  endtask

  task automatic version1_card();
    // two lost resets first
    start_test(2, 1'b1, 1'b0, 0, 1'b0, 1'b0);
    wait_outcome(1'b1);
    if (count_index(cmd0_idx) != 3) report_mismatch("CMD0 count", count_index(cmd0_idx), 3);
  endtask

  task automatic silent_card();
    start_test(0, 1'b0, 1'b0, 0, 1'b0, 1'b1);
    wait_outcome(1'b0);
    if (count_index(cmd0_idx) != max_retries) begin
      report_mismatch("CMD0 count", count_index(cmd0_idx), max_retries);
    end
    if (card.log_cnt != max_retries) report_mismatch("command count", card.log_cnt, max_retries);
  endtask

  task automatic wrong_echo();
    start_test(0, 1'b0, 1'b1, 0, 1'b1, 1'b0);
    wait_outcome(1'b0);
    if (card.log_cnt == 0) begin
      $display("[FAIL] %0t card logged no command at all", $time);
      errors++;
    end else if (card.log_idx[card.log_cnt - 1] != cmd8_idx) begin
      report_mismatch("last index", int'(card.log_idx[card.log_cnt - 1]), int'(cmd8_idx));
    end
  endtask

  task automatic endless_idle();
    start_test(0, 1'b0, 1'b0, 1000, 1'b1, 1'b0);
    wait_outcome(1'b0);
    if (count_index(acmd41_idx) != max_retries) begin
      report_mismatch("ACMD41 count", count_index(acmd41_idx), max_retries);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    cmd0_fails  = 0;
    v1_card     = 1'b0;
    bad_pattern = 1'b0;
    idle_count  = 0;
    ccs         = 1'b0;
    silent      = 1'b0;
    standard_hc_card();
    idle_then_ready();
    version1_card();
    silent_card();
    wrong_echo();
    endless_idle();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
source/sd_pkg.sv
source/sd_clk_gen.sv
source/sd_cmd_tx.sv
source/sd_resp_rx.sv
source/sd_init_fsm.sv
source/sd_spi_init.sv
verif/sd_card_model.sv
verif/tb_sd_spi_init.sv

// ==== Makefile ====
TOP := tb_sd_spi_init
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
